/* dv/jt12_tb.sv */
// Testbench for the JT12 register block, timers, status byte and PCM output
`timescale 1ns/1ps
`default_nettype none

module jt12_tb;
    import jt12_pkg::*;

    localparam int STEP_DELAY = 10;     // Input drive offset after the rising edge
    localparam int WAIT_LIMIT = 20000;  // Cycles allowed for any single wait

    logic                    clk;
    logic                    arst_n;
    logic                    cen;
    logic [7:0]              din;
    logic [1:0]              addr;
    logic                    cs_n;
    logic                    wr_n;
    logic [7:0]              dout;
    logic                    irq_n;
    logic signed [SND_W-1:0] snd_left;
    logic signed [SND_W-1:0] snd_right;
    logic                    snd_sample;

    int     errors;
    int     timeouts;
    int     cycle;   // Rising edges since time zero
    integer seed;

    jt12_top #(
        .TA_WIDTH ( TA_W        ),
        .TB_WIDTH ( TB_W        ),
        .TB_DIV   ( TB_PRESCALE )
    ) DUT (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Overflow to overflow distance in clk cycles with cen tied high
    function automatic int timer_period(input int value, input int width, input int prescale);
        return prescale * ((1 << width) - value) * CLK_DIV;
    endfunction

    // Offset binary sample re-centred on zero and scaled up to the output width
    function automatic logic signed [SND_W-1:0] pcm_expected(input logic [PCM_W-1:0] data,
                                                            input logic en);
        int level;
        if (!en) begin
            return '0;
        end
        level = (int'(data) - (1 << (PCM_W - 1))) * (1 << (SND_W - PCM_W - 1));
        return level[SND_W-1:0];
    endfunction

    task automatic step();
        @(posedge clk);
        #STEP_DELAY;
    endtask

    task automatic end_run();
        $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
    endtask

    // Poll one status bit until it reaches the given level
    task automatic wait_status(input int bit_idx, input logic level, input string what);
        int n;
        n = 0;
        while (dout[bit_idx] !== level && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (dout[bit_idx] !== level) begin
            timeouts++;
            $display("ERROR: timed out waiting for %s", what);
            end_run();
        end
    endtask

    task automatic wait_not_busy();
        wait_status(7, 1'b0, "busy flag to clear");
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        while (snd_sample !== 1'b1 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (snd_sample !== 1'b1) begin
            timeouts++;
            $display("ERROR: timed out waiting for a sample strobe");
            end_run();
        end
    endtask

    // One bus cycle with cs_n and wr_n low
    task automatic cpu_write(input logic [1:0] a, input logic [7:0] d);
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        step();
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_reg(input reg_addr_e r, input logic [7:0] d);
        wait_not_busy();
        cpu_write(2'd0, r);
        cpu_write(2'd1, d);
    endtask

    // Interval between two flag rises with a clear write in between
    task automatic measure_timer(input string name, input int bit_idx,
                                 input logic [7:0] ctrl_clr, input int expected);
        int t_first;
        int t_second;
        wait_status(bit_idx, 1'b1, {name, " first flag"});
        t_first = cycle;
        if (irq_n !== 1'b0) begin
            mismatch({name, " irq_n"}, 0, int'(irq_n));
        end
        write_reg(REG_TMR_CTRL, ctrl_clr);
        wait_status(bit_idx, 1'b0, {name, " flag clear"});
        wait_status(bit_idx, 1'b1, {name, " second flag"});
        t_second = cycle;
        if (t_second - t_first != expected) begin
            mismatch({name, " period"}, expected, t_second - t_first);
        end
    endtask

    initial begin
        logic [31:0]      rnd;
        logic [TA_W-1:0]  ta_val;
        logic [TB_W-1:0]  tb_val;
        logic [PCM_W-1:0] pcm_val;
        logic             pcm_on;
        logic             quiet;
        int               n;
        int               busy_min;
        int               busy_max;
        clk      = 1'b0;
        arst_n   = 1'b0;
        cen      = 1'b1;
        din      = 8'h00;
        addr     = 2'd0;
        cs_n     = 1'b1;
        wr_n     = 1'b1;
        errors   = 0;
        timeouts = 0;
        cycle    = 0;
        seed     = 32'h13f8_f42f;
        repeat (5) @(posedge clk);
        #STEP_DELAY;
        arst_n = 1'b1;
        step();

        if (irq_n !== 1'b1) begin
            mismatch("reset irq_n", 1, int'(irq_n));
        end
        if (dout !== 8'h00) begin
            mismatch("reset dout", 0, int'(dout));
        end
        if (snd_left !== '0) begin
            mismatch("reset snd_left", 0, int'(snd_left));
        end
        if (snd_right !== '0) begin
            mismatch("reset snd_right", 0, int'(snd_right));
        end
        if (snd_sample !== 1'b0) begin
            mismatch("reset snd_sample", 0, int'(snd_sample));
        end

        // Busy spans BUSY_CYCLES clk_en periods plus up to one period of alignment
        busy_min = BUSY_CYCLES * CLK_DIV;
        busy_max = busy_min + CLK_DIV - 1;
        wait_not_busy();
        cpu_write(2'd0, REG_PCM_DATA);
        cpu_write(2'd1, 8'h80);
        if (dout[7] !== 1'b1) begin
            mismatch("busy set", 1, int'(dout[7]));
        end
        n = 0;
        while (dout[7] === 1'b1 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (n < busy_min || n > busy_max) begin
            errors++;
            $display("FAILED busy length: expected %0d to %0d, actual %0d",
                     busy_min, busy_max, n);
        end

        rnd    = $random(seed);
        ta_val = {1'b0, rnd[TA_W-2:0]};  // Long enough to clear between overflows
        write_reg(REG_TA_HI, ta_val[TA_W-1:2]);
        write_reg(REG_TA_LO, {6'd0, ta_val[1:0]});
        write_reg(REG_TMR_CTRL, 8'h05);  // Load A, flag enable A
        measure_timer("timer A", 0, 8'h15, timer_period(int'(ta_val), TA_W, 1));

        write_reg(REG_TMR_CTRL, 8'h10);  // Stop A and drop its flag
        rnd    = $random(seed);
        tb_val = 8'd200 + {3'd0, rnd[4:0]};
        write_reg(REG_TB, tb_val);
        write_reg(REG_TMR_CTRL, 8'h0A);
        measure_timer("timer B", 1, 8'h2A,
                      timer_period(int'(tb_val), TB_W, TB_PRESCALE));

        // Running timer with its flag disabled
        write_reg(REG_TMR_CTRL, 8'h20);
        write_reg(REG_TA_HI, 8'hF0);     // 64 steps per period
        write_reg(REG_TA_LO, 8'h00);
        write_reg(REG_TMR_CTRL, 8'h01);
        quiet = 1'b1;
        for (int i = 0; i < 2 * timer_period(960, TA_W, 1); i++) begin
            step();
            if (dout[1:0] !== 2'b00 || irq_n !== 1'b1) begin
                quiet = 1'b0;
            end
        end
        if (!quiet) begin
            errors++;
            $display("ERROR: flag or IRQ appeared while the flag enable was clear");
        end

        write_reg(REG_TB, 8'hFF);
        write_reg(REG_TMR_CTRL, 8'h0F);  // Both timers running with both flags enabled
        wait_status(0, 1'b1, "flag A");
        wait_status(1, 1'b1, "flag B");
        write_reg(REG_TMR_CTRL, 8'h10);
        step();
        if (dout[1:0] !== 2'b10) begin
            mismatch("clear A flags", 2, int'(dout[1:0]));
        end
        if (irq_n !== 1'b0) begin
            mismatch("clear A irq_n", 0, int'(irq_n));
        end
        write_reg(REG_TMR_CTRL, 8'h20);
        step();
        if (dout[1:0] !== 2'b00) begin
            mismatch("clear B flags", 0, int'(dout[1:0]));
        end
        if (irq_n !== 1'b1) begin
            mismatch("clear B irq_n", 1, int'(irq_n));
        end

        for (int i = 0; i < 6; i++) begin
            rnd     = $random(seed);
            pcm_val = rnd[PCM_W-1:0];
            pcm_on  = ~i[0];
            write_reg(REG_PCM_DATA, pcm_val);
            write_reg(REG_PCM_EN, {pcm_on, 7'd0});
            wait_sample();  // May still carry the old sample
            step();
            if (snd_sample !== 1'b0) begin
                mismatch("sample pulse width", 0, int'(snd_sample));
            end
            wait_sample();
            if (snd_left !== pcm_expected(pcm_val, pcm_on)) begin
                mismatch("pcm left", int'(pcm_expected(pcm_val, pcm_on)), int'(snd_left));
            end
            if (snd_right !== pcm_expected(pcm_val, pcm_on)) begin
                mismatch("pcm right", int'(pcm_expected(pcm_val, pcm_on)), int'(snd_right));
            end
        end

        end_run();
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/jt12_pkg.sv
hdl/jt12_timer_if.sv
hdl/jt12_timer.sv
hdl/jt12_timers.sv
hdl/jt12_regs.sv
hdl/jt12_pcm_out.sv
hdl/jt12_top.sv
dv/jt12_tb.sv

/* hdl/jt12_pcm_out.sv */
// JT12 DAC path turning the PCM register into a signed stereo sample stream
`timescale 1ns/1ps
`default_nettype none

module jt12_pcm_out (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                clk_en,
    input  wire         [jt12_pkg::PCM_W-1:0]  pcm_data,
    input  wire                                pcm_en,
    output logic signed [jt12_pkg::SND_W-1:0]  snd_left,
    output logic signed [jt12_pkg::SND_W-1:0]  snd_right,
    output logic                               snd_sample
);
    import jt12_pkg::*;

    localparam int SCW       = $clog2(SAMPLE_DIV);
    localparam int DAC_SHIFT = SND_W - PCM_W - 1;

    logic [SCW-1:0]          smp_cnt;
    logic                    strobe;
    logic signed [PCM_W-1:0] pcm_s;
    logic signed [SND_W-1:0] dac;

    assign strobe = clk_en && (smp_cnt == SCW'(SAMPLE_DIV - 1));

    // Offset binary to two's complement, i.e. data minus 128
    assign pcm_s = {~pcm_data[PCM_W-1], pcm_data[PCM_W-2:0]};
    assign dac   = pcm_en ? (SND_W'(pcm_s) <<< DAC_SHIFT) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            smp_cnt <= '0;
        end else if (clk_en) begin
            if (strobe) begin
                smp_cnt <= '0;
            end else begin
                smp_cnt <= smp_cnt + 1'b1;
            end
        end
    end

    // Outputs move only together with the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_sample <= 1'b0;
            snd_left   <= '0;
            snd_right  <= '0;
        end else begin
            snd_sample <= strobe;
            if (strobe) begin
                snd_left  <= dac;   // Same sample on both channels
                snd_right <= dac;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/jt12_pkg.sv */
// JT12 register map, write FSM states and timing constants shared by all blocks
`default_nettype none

package jt12_pkg;

    // Register addresses handled in the lower bank
    typedef enum logic [7:0] {
        REG_TA_HI    = 8'h24,  // Timer A bits 9..2
        REG_TA_LO    = 8'h25,  // Timer A bits 1..0
        REG_TB       = 8'h26,
        REG_TMR_CTRL = 8'h27,  // Load, flag enable, flag clear
        REG_PCM_DATA = 8'h2A,  // Unsigned sample
        REG_PCM_EN   = 8'h2B
    } reg_addr_e;

    // Busy state after a data write
    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_BUSY = 1'b1
    } wr_state_e;

    // Bit positions inside REG_TMR_CTRL
    localparam int CTRL_LOAD_A = 0;
    localparam int CTRL_LOAD_B = 1;
    localparam int CTRL_FEN_A  = 2;
    localparam int CTRL_FEN_B  = 3;
    localparam int CTRL_CLR_A  = 4;
    localparam int CTRL_CLR_B  = 5;

    localparam int PCM_EN_BIT  = 7;  // In REG_PCM_EN

    // Widths
    localparam int TA_W        = 10;
    localparam int TB_W        = 8;
    localparam int PCM_W       = 8;
    localparam int SND_W       = 16;

    // Timing, counted in cen or clk_en pulses
    localparam int CLK_DIV     = 6;   // cen per clk_en
    localparam int TB_PRESCALE = 16;  // clk_en per timer B step
    localparam int BUSY_CYCLES = 32;
    localparam int SAMPLE_DIV  = 24;  // clk_en per output sample

endpackage

`default_nettype wire

/* hdl/jt12_regs.sv */
// JT12 register block with CPU write decode, clock-enable prescaler and busy flag
`timescale 1ns/1ps
`default_nettype none

module jt12_regs #(
    parameter int TA_WIDTH = jt12_pkg::TA_W
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         cen,      // External clock enable
    input  wire  [7:0]                  din,
    input  wire  [1:0]                  addr,
    input  wire                         cs_n,
    input  wire                         wr_n,

    output logic                        clk_en,   // Internal clock enable
    output logic                        busy,
    output logic [jt12_pkg::PCM_W-1:0]  pcm_data,
    output logic                        pcm_en,

    jt12_timer_if.regs                  tmr
);
    import jt12_pkg::*;

    localparam int CEN_CW  = $clog2(CLK_DIV);
    localparam int BUSY_CW = $clog2(BUSY_CYCLES + 1);

    logic               write;
    logic               addr_wr;
    logic               data_wr;
    logic [7:0]         reg_sel;   // Latched register address
    logic [CEN_CW-1:0]  cen_cnt;
    logic [BUSY_CW-1:0] busy_cnt;
    wr_state_e          wr_state;

    assign write   = ~cs_n & ~wr_n;
    assign addr_wr = write & (addr == 2'b00);
    assign data_wr = write & (addr == 2'b01);  // Upper bank never matches

    // Prescaler on cen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_cnt <= '0;
        end else if (cen) begin
            if (cen_cnt == CEN_CW'(CLK_DIV - 1)) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
        end
    end

    assign clk_en = cen && (cen_cnt == CEN_CW'(CLK_DIV - 1));

    // Address phase
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_sel <= '0;
        end else if (addr_wr) begin
            reg_sel <= din;
        end
    end

    // Data phase into timer and PCM registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tmr.value_a   <= '0;
            tmr.value_b   <= '0;
            tmr.load_a    <= 1'b0;
            tmr.load_b    <= 1'b0;
            tmr.flag_en_a <= 1'b0;
            tmr.flag_en_b <= 1'b0;
            tmr.clr_a     <= 1'b0;
            tmr.clr_b     <= 1'b0;
            pcm_data      <= '0;
            pcm_en        <= 1'b0;
        end else begin
            tmr.clr_a <= 1'b0;  // Pulses by default
            tmr.clr_b <= 1'b0;
            if (data_wr) begin
                case (reg_sel)
                    REG_TA_HI:    tmr.value_a[TA_WIDTH-1:2] <= din[TA_WIDTH-3:0];
                    REG_TA_LO:    tmr.value_a[1:0] <= din[1:0];
                    REG_TB:       tmr.value_b <= din;
                    REG_TMR_CTRL: begin
                        tmr.load_a    <= din[CTRL_LOAD_A];
                        tmr.load_b    <= din[CTRL_LOAD_B];
                        tmr.flag_en_a <= din[CTRL_FEN_A];
                        tmr.flag_en_b <= din[CTRL_FEN_B];
                        tmr.clr_a     <= din[CTRL_CLR_A];
                        tmr.clr_b     <= din[CTRL_CLR_B];
                    end
                    REG_PCM_DATA: pcm_data <= din;
                    REG_PCM_EN:   pcm_en <= din[PCM_EN_BIT];
                    default:      ;  // Unmapped address
                endcase
            end
        end
    end

    // Busy FSM
    // A clk_en in the write cycle itself counts as the first tick, so busy
    // spans BUSY_CYCLES full clk_en periods plus the initial alignment
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= WR_IDLE;
            busy_cnt <= '0;
        end else if (data_wr) begin
            wr_state <= WR_BUSY;
            busy_cnt <= BUSY_CW'(clk_en);  // Restart on every data write
        end else if (clk_en) begin
            case (wr_state)
                WR_BUSY: begin
                    if (busy_cnt == BUSY_CW'(BUSY_CYCLES)) begin
                        wr_state <= WR_IDLE;
                    end else begin
                        busy_cnt <= busy_cnt + 1'b1;
                    end
                end
                default: busy_cnt <= '0;
            endcase
        end
    end

    assign busy = (wr_state == WR_BUSY);

endmodule

`default_nettype wire

/* hdl/jt12_timer.sv */
// JT12 timer counter, a prescaled reloading up-counter that pulses on overflow
`timescale 1ns/1ps
`default_nettype none

module jt12_timer #(
    parameter int WIDTH    = 10,
    parameter int PRESCALE = 1     // clk_en pulses per count step
) (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              clk_en,
    input  wire  [WIDTH-1:0] value,
    input  wire              load,
    output logic             overflow
);
    localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PW-1:0]    pre_cnt;
    logic             tick;
    logic [WIDTH-1:0] cnt;

    // Free running prescaler, stays at zero when PRESCALE is 1
    assign tick = clk_en && (pre_cnt == PW'(PRESCALE - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt <= '0;
        end else if (clk_en) begin
            if (tick) begin
                pre_cnt <= '0;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (!load) begin
                cnt <= value;            // Hold reload value while stopped
            end else if (tick) begin
                if (&cnt) begin
                    cnt      <= value;
                    overflow <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/jt12_timer_if.sv */
// Timer settings and flags shared by the register block and the timer block
`timescale 1ns/1ps
`default_nettype none

interface jt12_timer_if #(
    parameter int TA_WIDTH = jt12_pkg::TA_W,
    parameter int TB_WIDTH = jt12_pkg::TB_W
);
    logic [TA_WIDTH-1:0] value_a;
    logic [TB_WIDTH-1:0] value_b;
    logic                load_a;
    logic                load_b;
    logic                flag_en_a;
    logic                flag_en_b;
    logic                clr_a;      // One clk pulse
    logic                clr_b;
    logic                flag_a;
    logic                flag_b;

    modport regs (
        output value_a, value_b, load_a, load_b,
        output flag_en_a, flag_en_b, clr_a, clr_b
    );

    modport timers (
        input  value_a, value_b, load_a, load_b,
        input  flag_en_a, flag_en_b, clr_a, clr_b,
        output flag_a, flag_b
    );

endinterface

`default_nettype wire

/* hdl/jt12_timers.sv */
// JT12 timers A and B with status flags and interrupt request
`timescale 1ns/1ps
`default_nettype none

module jt12_timers #(
    parameter int TA_WIDTH = jt12_pkg::TA_W,
    parameter int TB_WIDTH = jt12_pkg::TB_W,
    parameter int TB_DIV   = jt12_pkg::TB_PRESCALE
) (
    input  wire          clk,
    input  wire          arst_n,
    input  wire          clk_en,
    output logic         irq_n,

    jt12_timer_if.timers tmr
);
    logic ovf_a;
    logic ovf_b;

    // Timer A steps on every clk_en
    jt12_timer #(
        .WIDTH    ( TA_WIDTH ),
        .PRESCALE ( 1        )
    ) u_timer_a (
        .clk      ( clk         ),
        .arst_n   ( arst_n      ),
        .clk_en   ( clk_en      ),
        .value    ( tmr.value_a ),
        .load     ( tmr.load_a  ),
        .overflow ( ovf_a       )
    );

    jt12_timer #(
        .WIDTH    ( TB_WIDTH ),
        .PRESCALE ( TB_DIV   )
    ) u_timer_b (
        .clk      ( clk         ),
        .arst_n   ( arst_n      ),
        .clk_en   ( clk_en      ),
        .value    ( tmr.value_b ),
        .load     ( tmr.load_b  ),
        .overflow ( ovf_b       )
    );

    // Flags are sticky, clear has priority over a new overflow
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tmr.flag_a <= 1'b0;
            tmr.flag_b <= 1'b0;
        end else begin
            if (tmr.clr_a) begin
                tmr.flag_a <= 1'b0;
            end else if (ovf_a && tmr.flag_en_a) begin
                tmr.flag_a <= 1'b1;
            end
            if (tmr.clr_b) begin
                tmr.flag_b <= 1'b0;
            end else if (ovf_b && tmr.flag_en_b) begin
                tmr.flag_b <= 1'b1;
            end
        end
    end

    assign irq_n = ~(tmr.flag_a | tmr.flag_b);

endmodule

`default_nettype wire

/* hdl/jt12_top.sv */
// JT12 top level with register, timer and PCM blocks plus the status byte
`timescale 1ns/1ps
`default_nettype none

module jt12_top #(
    parameter int TA_WIDTH = jt12_pkg::TA_W,
    parameter int TB_WIDTH = jt12_pkg::TB_W,
    parameter int TB_DIV   = jt12_pkg::TB_PRESCALE
) (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                cen,    // Tie to 1 if unused
    input  wire         [7:0]                  din,
    input  wire         [1:0]                  addr,
    input  wire                                cs_n,
    input  wire                                wr_n,

    output logic        [7:0]                  dout,
    output logic                               irq_n,
    output logic signed [jt12_pkg::SND_W-1:0]  snd_left,
    output logic signed [jt12_pkg::SND_W-1:0]  snd_right,
    output logic                               snd_sample
);
    import jt12_pkg::*;

    logic             clk_en;
    logic             busy;
    logic [PCM_W-1:0] pcm_data;
    logic             pcm_en;

    jt12_timer_if #(
        .TA_WIDTH ( TA_WIDTH ),
        .TB_WIDTH ( TB_WIDTH )
    ) tmr_if ();

    jt12_regs #(
        .TA_WIDTH ( TA_WIDTH )
    ) u_regs (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cen      ( cen      ),
        .din      ( din      ),
        .addr     ( addr     ),
        .cs_n     ( cs_n     ),
        .wr_n     ( wr_n     ),
        .clk_en   ( clk_en   ),
        .busy     ( busy     ),
        .pcm_data ( pcm_data ),
        .pcm_en   ( pcm_en   ),
        .tmr      ( tmr_if   )
    );

    jt12_timers #(
        .TA_WIDTH ( TA_WIDTH ),
        .TB_WIDTH ( TB_WIDTH ),
        .TB_DIV   ( TB_DIV   )
    ) u_timers (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .clk_en   ( clk_en   ),
        .irq_n    ( irq_n    ),
        .tmr      ( tmr_if   )
    );

    jt12_pcm_out u_pcm_out (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .clk_en     ( clk_en     ),
        .pcm_data   ( pcm_data   ),
        .pcm_en     ( pcm_en     ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    // Status byte, same on every read address
    assign dout = {busy, 5'd0, tmr_if.flag_b, tmr_if.flag_a};

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the JT12 testbench with Verilator, run it and check the log

rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module jt12_tb -f flist.f > build.log 2>&1 \
    && ./obj_dir/Vjt12_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Result: fail"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Result: no verdict in log"; exit 1; }
echo "Result: pass"
